//--- Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ee_host_pkg.sv
      - common/ee_bus_pkg.sv
      - hw/host_req_port.sv
      - serial_master/bit_shifter.sv
      - serial_master/serial_master.sv
      - hw/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/eeprom_slave_model.sv
      - test/eeprom_ctrl_tb.sv

//--- common/ee_bus_pkg.sv
`include "eeprom_params.svh"

package ee_bus_pkg;

    // a byte on the wire, plain or as control byte
    typedef union packed {
        logic [`EE_DATA_W-1:0] raw;
        struct packed {
            logic [3:0] dev;    // device type
            logic [2:0] block;  // address bits 10:8
            logic       rw;     // 1 for read
        } ctrl;
    } ee_byte_u;

    // byte level jobs for the shifter
    typedef enum logic [1:0] {
        BIT_START = 2'd0,   // repeated start too
        BIT_WRITE = 2'd1,
        BIT_READ  = 2'd2,
        BIT_STOP  = 2'd3
    } ee_bit_op_e;

endpackage

//--- common/ee_host_pkg.sv
`include "eeprom_params.svh"

package ee_host_pkg;

    // byte address inside the whole array
    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;

    typedef enum logic {
        HOST_WRITE = 1'b0,
        HOST_READ  = 1'b1
    } ee_host_op_e;

endpackage

//--- common/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// 2 KB part, bits 10:8 travel in the control byte
`define EE_ADDR_W 11

`define EE_DATA_W 8

// device type code of serial EEPROMs
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of one SCL bit
// four quarters make one bit
`define EE_QTR_CYC 4

`endif

//--- hw/eeprom_ctrl_top.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module eeprom_ctrl_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req,
    input  ee_host_pkg::ee_host_op_e  op,
    input  ee_host_pkg::ee_addr_t     addr,
    input  logic [`EE_DATA_W-1:0]     wdata,
    output logic                      ack,
    output logic [`EE_DATA_W-1:0]     rdata,
    output logic                      err,
    output logic                      scl,
    output logic                      sda_pull_low,
    input  logic                      sda_in
);
    import ee_host_pkg::*;
    import ee_bus_pkg::*;

    logic                  xfer_go;
    ee_host_op_e           xfer_op;
    ee_addr_t              xfer_addr;
    logic [`EE_DATA_W-1:0] xfer_wdata;
    logic                  xfer_done;
    logic [`EE_DATA_W-1:0] xfer_rdata;
    logic                  xfer_nack;
    logic                  bit_go;
    ee_bit_op_e            bit_op;
    ee_byte_u              tx_byte;
    logic                  master_nack;
    logic                  bit_done;
    logic [`EE_DATA_W-1:0] rx_byte;
    logic                  slave_nack;

    host_req_port u_host (.CLK, .RESET, .req, .op, .addr, .wdata, .xfer_done, .xfer_rdata,
        .xfer_nack, .ack, .rdata, .err, .xfer_go, .xfer_op, .xfer_addr, .xfer_wdata);

    serial_master u_master (.CLK, .RESET, .xfer_go, .xfer_op, .xfer_addr, .xfer_wdata,
        .bit_done, .rx_byte, .slave_nack, .xfer_done, .xfer_rdata, .xfer_nack, .bit_go,
        .bit_op, .tx_byte, .master_nack);

    bit_shifter u_shifter (.CLK, .RESET, .bit_go, .bit_op, .tx_byte, .master_nack, .sda_in,
        .bit_done, .rx_byte, .slave_nack, .scl, .sda_pull_low);

endmodule

//--- hw/host_req_port.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module host_req_port (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req,
    input  ee_host_pkg::ee_host_op_e  op,
    input  ee_host_pkg::ee_addr_t     addr,
    input  logic [`EE_DATA_W-1:0]     wdata,
    input  logic                      xfer_done,
    input  logic [`EE_DATA_W-1:0]     xfer_rdata,
    input  logic                      xfer_nack,
    output logic                      ack,
    output logic [`EE_DATA_W-1:0]     rdata,
    output logic                      err,
    output logic                      xfer_go,
    output ee_host_pkg::ee_host_op_e  xfer_op,
    output ee_host_pkg::ee_addr_t     xfer_addr,
    output logic [`EE_DATA_W-1:0]     xfer_wdata
);
    localparam logic [1:0] H_IDLE = 2'd0;
    localparam logic [1:0] H_BUSY = 2'd1;
    localparam logic [1:0] H_ACK  = 2'd2;

    logic [1:0] state;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= H_IDLE;
            ack     <= 1'b0;
            rdata   <= '0;
            err     <= 1'b0;
            xfer_go <= 1'b0;
        end
        else
        begin
            xfer_go <= 1'b0;
            case (state)
                H_IDLE:
                    if (req)
                    begin
                        xfer_go <= 1'b1;
                        state   <= H_BUSY;
                    end
                H_BUSY:
                    if (xfer_done)
                    begin
                        ack   <= 1'b1;
                        rdata <= xfer_rdata;    // held until next transfer ends
                        err   <= xfer_nack;
                        state <= H_ACK;
                    end
                default:
                    if (!req)   // host done with result
                    begin
                        ack   <= 1'b0;
                        state <= H_IDLE;
                    end
            endcase
        end
    end

    // request latched as the transfer starts
    always_ff @(posedge CLK)
    begin
        if (state == H_IDLE && req)
        begin
            xfer_op    <= op;
            xfer_addr  <= addr;
            xfer_wdata <= wdata;
        end
    end

    a_ack_with_req: assert property (@(posedge CLK) disable iff (RESET) $rose(ack) |-> req);

endmodule

//--- serial_master/bit_shifter.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module bit_shifter (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    bit_go,
    input  ee_bus_pkg::ee_bit_op_e  bit_op,
    input  ee_bus_pkg::ee_byte_u    tx_byte,
    input  logic                    master_nack,
    input  logic                    sda_in,
    output logic                    bit_done,
    output logic [`EE_DATA_W-1:0]   rx_byte,
    output logic                    slave_nack,
    output logic                    scl,
    output logic                    sda_pull_low
);
    import ee_bus_pkg::*;

    localparam int QW = $clog2(`EE_QTR_CYC + 1);

    localparam logic [2:0] B_IDLE  = 3'd0;
    localparam logic [2:0] B_START = 3'd1;
    localparam logic [2:0] B_STOP  = 3'd2;
    localparam logic [2:0] B_WRITE = 3'd3;
    localparam logic [2:0] B_READ  = 3'd4;

    logic [2:0]    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    q;       // quarter within the bit
    logic [3:0]    bcnt;    // 8 is the ack bit
    logic          q_end;
    ee_byte_u      shreg;
    logic          mnack_q;

    assign q_end   = (state != B_IDLE) && (qcnt == QW'(`EE_QTR_CYC - 1));
    assign rx_byte = shreg.raw;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= B_IDLE;
            qcnt     <= '0;
            q        <= 2'd0;
            bcnt     <= 4'd0;
            bit_done <= 1'b0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (state == B_IDLE)
            begin
                qcnt <= '0;
                q    <= 2'd0;
                bcnt <= 4'd0;
                if (bit_go)
                    case (bit_op)
                        BIT_START: state <= B_START;
                        BIT_STOP:  state <= B_STOP;
                        BIT_WRITE: state <= B_WRITE;
                        default:   state <= B_READ;
                    endcase
            end
            else if (q_end)
            begin
                qcnt <= '0;
                q    <= q + 2'd1;
                if (q == 2'd3)
                begin
                    if (state == B_START || state == B_STOP || bcnt[3])
                    begin
                        state    <= B_IDLE;
                        bit_done <= 1'b1;
                    end
                    else
                        bcnt <= bcnt + 4'd1;
                end
            end
            else
                qcnt <= qcnt + QW'(1);
        end
    end

    // sample point is the start of the third quarter
    always_ff @(posedge CLK)
    begin
        if (state == B_IDLE && bit_go)
        begin
            shreg   <= tx_byte;
            mnack_q <= master_nack;
        end
        else if (q_end && !bcnt[3])
        begin
            if (state == B_READ && q == 2'd1)
                shreg.raw <= {shreg.raw[`EE_DATA_W-2:0], sda_in};
            if (state == B_WRITE && q == 2'd3)
                shreg.raw <= {shreg.raw[`EE_DATA_W-2:0], 1'b0};
        end
        if (state == B_WRITE && bcnt[3] && q == 2'd1 && q_end)
            slave_nack <= sda_in;
    end

    always_comb
    begin
        scl          = 1'b1;    // idle bus
        sda_pull_low = 1'b0;
        case (state)
            B_START:
            begin
                scl          = q[0] ^ q[1];
                sda_pull_low = q[1];    // falls while scl high
            end
            B_STOP:
            begin
                scl          = (q != 2'd0);
                sda_pull_low = !q[1];   // released while scl high
            end
            B_WRITE:
            begin
                scl          = q[0] ^ q[1];
                sda_pull_low = !bcnt[3] && !shreg.raw[`EE_DATA_W-1];
            end
            B_READ:
            begin
                scl          = q[0] ^ q[1];
                sda_pull_low = bcnt[3] && !mnack_q;
            end
            default: ;
        endcase
    end

    a_go_when_idle: assert property (@(posedge CLK) disable iff (RESET) bit_go |-> state == B_IDLE);

endmodule

//--- serial_master/serial_master.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module serial_master (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      xfer_go,
    input  ee_host_pkg::ee_host_op_e  xfer_op,
    input  ee_host_pkg::ee_addr_t     xfer_addr,
    input  logic [`EE_DATA_W-1:0]     xfer_wdata,
    input  logic                      bit_done,
    input  logic [`EE_DATA_W-1:0]     rx_byte,
    input  logic                      slave_nack,
    output logic                      xfer_done,
    output logic [`EE_DATA_W-1:0]     xfer_rdata,
    output logic                      xfer_nack,
    output logic                      bit_go,
    output ee_bus_pkg::ee_bit_op_e    bit_op,
    output ee_bus_pkg::ee_byte_u      tx_byte,
    output logic                      master_nack
);
    import ee_host_pkg::*;
    import ee_bus_pkg::*;

    localparam logic [3:0] P_IDLE   = 4'd0;
    localparam logic [3:0] P_START  = 4'd1;
    localparam logic [3:0] P_CTRL_W = 4'd2;
    localparam logic [3:0] P_ADDR   = 4'd3;
    localparam logic [3:0] P_DATA   = 4'd4;
    localparam logic [3:0] P_RSTART = 4'd5;
    localparam logic [3:0] P_CTRL_R = 4'd6;
    localparam logic [3:0] P_READ   = 4'd7;
    localparam logic [3:0] P_STOP   = 4'd8;

    logic [3:0]            phase;
    logic [3:0]            nxt_phase;
    ee_bit_op_e            nxt_op;
    ee_byte_u              nxt_byte;
    logic                  nxt_mnack;
    logic                  wr_phase;
    logic                  nack_seen;
    ee_host_op_e           op_q;
    ee_addr_t              addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;

    // what follows the phase that just finished
    always_comb
    begin
        wr_phase = (phase == P_CTRL_W) || (phase == P_ADDR) ||
                   (phase == P_DATA) || (phase == P_CTRL_R);
        nxt_phase    = P_STOP;
        nxt_op       = BIT_STOP;
        nxt_byte.raw = '0;
        nxt_mnack    = 1'b0;
        case (phase)
            P_START, P_RSTART:
            begin
                nxt_phase           = (phase == P_START) ? P_CTRL_W : P_CTRL_R;
                nxt_op              = BIT_WRITE;
                nxt_byte.ctrl.dev   = `EE_DEV_CODE;
                nxt_byte.ctrl.block = addr_q[`EE_ADDR_W-1:8];
                nxt_byte.ctrl.rw    = (phase == P_RSTART);
            end
            P_CTRL_W:
            begin
                nxt_phase    = P_ADDR;
                nxt_op       = BIT_WRITE;
                nxt_byte.raw = addr_q[7:0];
            end
            P_ADDR:
                if (op_q == HOST_WRITE)
                begin
                    nxt_phase    = P_DATA;
                    nxt_op       = BIT_WRITE;
                    nxt_byte.raw = wdata_q;
                end
                else
                begin
                    nxt_phase = P_RSTART;
                    nxt_op    = BIT_START;
                end
            P_CTRL_R:
            begin
                nxt_phase = P_READ;
                nxt_op    = BIT_READ;
                nxt_mnack = 1'b1;   // only byte, so no ack
            end
            default: ;  // data or read byte done
        endcase
        if (wr_phase && slave_nack) // abort on any refused byte
        begin
            nxt_phase = P_STOP;
            nxt_op    = BIT_STOP;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase      <= P_IDLE;
            bit_go     <= 1'b0;
            xfer_done  <= 1'b0;
            xfer_nack  <= 1'b0;
            xfer_rdata <= '0;
            nack_seen  <= 1'b0;
        end
        else
        begin
            bit_go    <= 1'b0;
            xfer_done <= 1'b0;
            if (phase == P_IDLE)
            begin
                if (xfer_go)
                begin
                    bit_go    <= 1'b1;
                    phase     <= P_START;
                    nack_seen <= 1'b0;
                end
            end
            else if (bit_done)
            begin
                if (phase == P_READ)
                    xfer_rdata <= rx_byte;
                if (phase == P_STOP)
                begin
                    xfer_done <= 1'b1;
                    xfer_nack <= nack_seen;
                    phase     <= P_IDLE;
                end
                else
                begin
                    bit_go <= 1'b1;
                    phase  <= nxt_phase;
                    if (wr_phase && slave_nack)
                        nack_seen <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (phase == P_IDLE && xfer_go)
        begin
            op_q    <= xfer_op;
            addr_q  <= xfer_addr;
            wdata_q <= xfer_wdata;
            bit_op  <= BIT_START;
        end
        else if (bit_done)
        begin
            bit_op      <= nxt_op;
            tx_byte     <= nxt_byte;
            master_nack <= nxt_mnack;
        end
    end

    a_one_xfer: assert property (@(posedge CLK) disable iff (RESET) xfer_go |-> phase == P_IDLE);

endmodule

//--- tb.f
+incdir+common
common/ee_host_pkg.sv
common/ee_bus_pkg.sv
hw/host_req_port.sv
serial_master/bit_shifter.sv
serial_master/serial_master.sv
hw/eeprom_ctrl_top.sv
test/eeprom_slave_model.sv
test/eeprom_ctrl_tb.sv

//--- test/eeprom_ctrl_tb.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module eeprom_ctrl_tb;
    import ee_host_pkg::*;

    localparam int N_REQ = 200;
    localparam int unsigned CYC_LIMIT = N_REQ * 50 * 4 * `EE_QTR_CYC * 2;

    logic        CLK;
    logic        RESET;
    logic        req;
    ee_host_op_e op;
    ee_addr_t    addr;
    logic [7:0]  wdata;
    logic        ack;
    logic [7:0]  rdata;
    logic        err;
    logic        scl;
    logic        sda_pull_low;
    logic        slave_low;
    logic        sda;
    logic        nack_inj;
    logic        proto_err;
    logic        ack_q;
    logic [7:0]  rdata_q;
    logic        err_q;

    logic [7:0]  ref_mem [0:2047];
    logic        written [0:2047];
    int unsigned cycles = 0;
    int          n_nack = 0;
    int          n_hits = 0;
    int          n_fill = 0;

    // open drain bus, low if anyone pulls
    assign sda = (sda_pull_low === 1'b1 || slave_low === 1'b1) ? 1'b0 : 1'b1;

    eeprom_ctrl_top u_dut (.CLK, .RESET, .req, .op, .addr, .wdata, .ack, .rdata, .err, .scl,
        .sda_pull_low, .sda_in(sda));

    eeprom_slave_model u_slave (.CLK, .RESET, .scl, .sda, .nack_ctrl(nack_inj),
        .sda_low(slave_low), .proto_err);

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [7:0] fill_value(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b01011};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // one four-phase request, entered and left on a clock edge
    task automatic run_request(input ee_host_op_e o, input ee_addr_t a, input logic [7:0] d,
                               input logic inj, output logic [7:0] got_rdata,
                               output logic got_err);
        req      <= 1'b1;
        op       <= o;
        addr     <= a;
        wdata    <= d;
        nack_inj <= inj;
        do
            @(posedge CLK);
        while (ack !== 1'b1);
        got_rdata = rdata;
        got_err   = err;
        req <= 1'b0;
        do
            @(posedge CLK);
        while (ack !== 1'b0);
    endtask

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles > CYC_LIMIT)
            fail_run("run passed its cycle limit without finishing");
    end

    // handshake order and result hold
    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            assert (!proto_err) else fail_run("slave model flagged a bus protocol error");
            if (ack && !ack_q)
                assert (req) else fail_run("ack rose while req was low");
            if (!ack && ack_q)
                assert (!req) else fail_run("ack fell while req was still high");
            if (ack && ack_q)
            begin
                assert (rdata == rdata_q)
                    else fail_run($sformatf("MISMATCH rdata: got %h, expected %h",
                                            rdata, rdata_q));
                assert (err == err_q)
                    else fail_run($sformatf("MISMATCH err: got %h, expected %h", err, err_q));
            end
        end
        ack_q   <= ack;
        rdata_q <= rdata;
        err_q   <= err;
    end

    initial
    begin
        ee_host_op_e op_v;
        ee_addr_t    addr_v;
        logic [7:0]  data_v;
        logic [7:0]  exp_v;
        logic [7:0]  got_rdata;
        logic        got_err;
        logic        inj_v;
        logic [31:0] rnd;
        RESET    = 1'b1;
        req      = 1'b0;
        op       = HOST_WRITE;
        addr     = '0;
        wdata    = '0;
        nack_inj = 1'b0;
        void'($urandom(32'h2c06));
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = fill_value(11'(i));
            written[i] = 1'b0;
        end
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4)
        begin
            @(posedge CLK);
            assert (ack === 1'b0)
                else fail_run($sformatf("MISMATCH ack: got %h, expected %h", ack, 1'b0));
            assert (scl === 1'b1)
                else fail_run($sformatf("MISMATCH scl: got %h, expected %h", scl, 1'b1));
            assert (sda_pull_low === 1'b0)
                else fail_run($sformatf("MISMATCH sda_pull_low: got %h, expected %h",
                                        sda_pull_low, 1'b0));
        end
        for (int n = 0; n < N_REQ; n++)
        begin
            rnd    = $urandom;
            op_v   = rnd[0] ? HOST_READ : HOST_WRITE;
            inj_v  = (rnd[3:1] == 3'd0);    // one in eight
            data_v = rnd[15:8];
            if (rnd[5:4] == 2'd0)
                addr_v = ee_addr_t'($urandom);
            else
                addr_v = {rnd[18:16], 6'b011010, rnd[20:19]};  // small reused set, all blocks
            exp_v = ref_mem[addr_v];
            if (rnd[23:21] == 3'd0)
                repeat (rnd[25:24]) @(posedge CLK);
            run_request(op_v, addr_v, data_v, inj_v, got_rdata, got_err);
            assert (got_err == inj_v)
                else fail_run($sformatf("MISMATCH err: got %h, expected %h", got_err, inj_v));
            if (inj_v)
                n_nack++;
            else if (op_v == HOST_READ)
            begin
                assert (got_rdata == exp_v)
                    else fail_run($sformatf("MISMATCH rdata: got %h, expected %h",
                                            got_rdata, exp_v));
                if (written[addr_v])
                    n_hits++;
                else
                    n_fill++;
            end
            else
            begin
                ref_mem[addr_v] = data_v;
                written[addr_v] = 1'b1;
            end
        end
        if (n_nack > 0 && n_hits > 0 && n_fill > 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
            fail_run("random requests missed a NACK, a read after write or a fill read");
    end

endmodule

//--- test/eeprom_slave_model.sv
`timescale 1ns/100ps
`include "eeprom_params.svh"

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_ctrl,     // refuse the first control byte
    output logic sda_low,
    output logic proto_err
);
    logic [7:0] mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic [7:0] high_cnt;       // samples since scl rose
    logic       moved;          // sda edge inside this high phase
    logic       active;
    logic       first_ctrl;
    logic       rd_mode;
    logic       acked;
    logic       rw_bit;
    logic [3:0] bitn;
    logic [1:0] byte_idx;
    logic [7:0] shreg;
    logic [7:0] tx_q;
    logic [2:0] block;
    logic [7:0] word;

    // fill pattern, keyed by block and word
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'b01011};
    end

    task automatic protocol_error(input string what);
        $display("slave model: %s", what);
        proto_err <= 1'b1;
    endtask

    always @(posedge CLK)
    begin
        logic [7:0] nb;
        logic       ack_v;
        if (RESET)
        begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            high_cnt  <= 8'd0;
            moved     <= 1'b0;
            active    <= 1'b0;
            rd_mode   <= 1'b0;
            bitn      <= 4'd0;
            byte_idx  <= 2'd0;
            sda_low   <= 1'b0;
            proto_err <= 1'b0;
        end
        else
        begin
            scl_q    <= scl;
            sda_q    <= sda;
            high_cnt <= scl ? high_cnt + 8'd1 : 8'd0;
            if (scl && !scl_q)
                moved <= 1'b0;
            if (scl && scl_q && sda != sda_q)   // start or stop
            begin
                moved    <= 1'b1;
                if (active && bitn != 4'd0)
                    protocol_error("start or stop arrived in the middle of a byte");
                sda_low  <= 1'b0;
                bitn     <= 4'd0;
                byte_idx <= 2'd0;
                rd_mode  <= 1'b0;
                if (!sda)
                begin
                    first_ctrl <= !active;  // repeated start keeps the transaction
                    active     <= 1'b1;
                end
                else
                    active <= 1'b0;
            end
            // short scl high between byte jobs is the idle bus, not a bit
            else if (!scl && scl_q && active && !moved && high_cnt >= `EE_QTR_CYC)
            begin
                bitn <= bitn + 4'd1;
                if (bitn == 4'd8)
                begin
                    bitn    <= 4'd0;
                    sda_low <= 1'b0;
                    if (rd_mode)
                    begin
                        if (!sda_q)
                            protocol_error("master acknowledged a single read byte");
                    end
                    else
                    begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd0 && rw_bit && acked)
                        begin
                            rd_mode <= 1'b1;
                            tx_q    <= mem[{block, word}];
                            sda_low <= !mem[{block, word}][7];
                        end
                    end
                end
                else if (rd_mode)
                    sda_low <= (bitn == 4'd7) ? 1'b0 : !tx_q[3'(4'd6 - bitn)];
                else
                begin
                    nb    = {shreg[6:0], sda_q};
                    shreg <= nb;
                    if (bitn == 4'd7)
                    begin
                        ack_v = 1'b1;
                        case (byte_idx)
                            2'd0:
                            begin
                                if (nb[7:4] != `EE_DEV_CODE)
                                begin
                                    protocol_error("control byte carries a wrong device code");
                                    ack_v = 1'b0;
                                end
                                if (nack_ctrl && first_ctrl)
                                    ack_v = 1'b0;
                                block  <= nb[3:1];
                                rw_bit <= nb[0];
                            end
                            2'd1: word <= nb;
                            2'd2: mem[{block, word}] <= nb;
                            default:
                            begin
                                protocol_error("more than one data byte in a write");
                                ack_v = 1'b0;
                            end
                        endcase
                        acked   <= ack_v;
                        sda_low <= ack_v;
                    end
                end
            end
        end
    end

endmodule
